// ==== logic/rv_isa_pkg.sv ====
// RV32I instruction set constants: field positions, opcodes and function codes
package rv_isa_pkg;

    typedef logic [31:0] inst_t;    // Full instruction word
    typedef logic [6:0]  opcode_t;  // Major opcode
    typedef logic [2:0]  funct3_t;  // Minor opcode
    typedef logic [6:0]  funct7_t;  // Upper function field

    // Bit positions inside inst_t
    localparam int OPCODE_LSB = 0;
    localparam int OPCODE_MSB = 6;
    localparam int FUNCT3_LSB = 12;
    localparam int FUNCT3_MSB = 14;
    localparam int FUNCT7_LSB = 25;
    localparam int FUNCT7_MSB = 31;

    // Major opcodes handled by the decoder
    localparam opcode_t OPC_OP     = 7'b0110011;  // R-type ALU
    localparam opcode_t OPC_OP_IMM = 7'b0010011;  // I-type ALU
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;  // Ecall, ebreak, csr

    localparam funct7_t F7_BASE = 7'b0000000;  // Normal form
    localparam funct7_t F7_ALT  = 7'b0100000;  // Sub and arithmetic shift

    // Branch conditions
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // Shift group, funct7 is meaningful only here for OP_IMM
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SRL_SRA = 3'b101;

    // Load and store sizes, passed through as the access code
    localparam funct3_t F3_B  = 3'b000;
    localparam funct3_t F3_H  = 3'b001;
    localparam funct3_t F3_W  = 3'b010;
    localparam funct3_t F3_BU = 3'b100;  // Loads only
    localparam funct3_t F3_HU = 3'b101;  // Loads only

    localparam inst_t EBREAK_WORD = 32'h0010_0073;  // Exact ebreak encoding

endpackage

// ==== logic/core_ctrl_pkg.sv ====
// Control encodings driven from decode into the execute stage of the core
package core_ctrl_pkg;

    typedef logic [4:0] alu_op_t;      // ALU function
    typedef logic [1:0] op1_sel_t;     // Operand 1 source
    typedef logic [1:0] op2_sel_t;     // Operand 2 source
    typedef logic [2:0] pc_sel_t;      // Next PC source
    typedef logic [1:0] wb_sel_t;      // Write-back source
    typedef logic [2:0] mem_access_t;  // Load or store size, same code as funct3

    // ALU functions
    localparam alu_op_t ALU_ADD  = 5'd0;
    localparam alu_op_t ALU_SUB  = 5'd1;
    localparam alu_op_t ALU_SLT  = 5'd2;
    localparam alu_op_t ALU_SLTU = 5'd3;
    localparam alu_op_t ALU_XOR  = 5'd4;
    localparam alu_op_t ALU_OR   = 5'd5;
    localparam alu_op_t ALU_AND  = 5'd6;
    localparam alu_op_t ALU_SLL  = 5'd7;
    localparam alu_op_t ALU_SRL  = 5'd8;
    localparam alu_op_t ALU_SRA  = 5'd9;

    localparam op1_sel_t OP1_RS1 = 2'd0;
    localparam op1_sel_t OP1_PC  = 2'd1;  // Auipc

    localparam op2_sel_t OP2_NONE  = 2'd0;
    localparam op2_sel_t OP2_IMM_I = 2'd1;
    localparam op2_sel_t OP2_IMM_S = 2'd2;  // Store offset
    localparam op2_sel_t OP2_RS2   = 2'd3;

    localparam pc_sel_t PC_SEQ    = 3'd0;  // Pc + 4
    localparam pc_sel_t PC_JALR   = 3'd1;
    localparam pc_sel_t PC_BRANCH = 3'd2;  // Taken branch
    localparam pc_sel_t PC_JAL    = 3'd3;  // Highest legal code

    localparam wb_sel_t WB_NONE = 2'd0;
    localparam wb_sel_t WB_LINK = 2'd1;  // Pc + 4 into rd
    localparam wb_sel_t WB_ALU  = 2'd2;
    localparam wb_sel_t WB_MEM  = 2'd3;

    localparam mem_access_t MEM_ACCESS_NONE = 3'd0;  // No memory access

endpackage

// ==== logic/inst_ctrl_table.sv ====
// Instruction decode table: RV32I word to ALU, operand, PC, memory and write-back controls
`timescale 1ns/1ps

module inst_ctrl_table (
    input  rv_isa_pkg::inst_t           inst,
    output core_ctrl_pkg::alu_op_t      alu_op,
    output core_ctrl_pkg::op1_sel_t     op1_sel,
    output core_ctrl_pkg::op2_sel_t     op2_sel,
    output core_ctrl_pkg::pc_sel_t      static_pc_sel,  // Jumps only, branches resolved later
    output logic                        rf_we,
    output logic                        mem_en,
    output logic                        mem_wen,
    output core_ctrl_pkg::wb_sel_t      wb_sel,
    output core_ctrl_pkg::mem_access_t  mem_access,
    output logic                        is_branch,
    output logic                        is_ebreak
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    logic    sub_sra;  // Alternate form requested
    logic    legal;    // Encoding is one we execute
    alu_op_t alu_fn;   // Shared R/I ALU function

    assign opcode = inst[OPCODE_MSB:OPCODE_LSB];
    assign funct3 = inst[FUNCT3_MSB:FUNCT3_LSB];
    assign funct7 = inst[FUNCT7_MSB:FUNCT7_LSB];

    // Upper bits are immediate for non-shift OP_IMM, so alt only counts there on shifts
    assign sub_sra = (funct7 == F7_ALT) && (opcode == OPC_OP || funct3 == F3_SRL_SRA);

    always_comb begin
        case (funct3)
            3'b000:     alu_fn = sub_sra ? ALU_SUB : ALU_ADD;
            F3_SLL:     alu_fn = ALU_SLL;
            3'b010:     alu_fn = ALU_SLT;
            3'b011:     alu_fn = ALU_SLTU;
            3'b100:     alu_fn = ALU_XOR;
            F3_SRL_SRA: alu_fn = sub_sra ? ALU_SRA : ALU_SRL;  // Srli gets srl
            3'b110:     alu_fn = ALU_OR;
            default:    alu_fn = ALU_AND;                      // 111
        endcase
    end

    // Legality per opcode
    always_comb begin
        case (opcode)
            OPC_OP:     legal = (funct7 == F7_BASE) ||
                                (funct7 == F7_ALT && (funct3 == 3'b000 || funct3 == F3_SRL_SRA));
            OPC_OP_IMM: legal = (funct3 != F3_SLL && funct3 != F3_SRL_SRA) ||
                                (funct7 == F7_BASE) ||
                                (funct7 == F7_ALT && funct3 == F3_SRL_SRA);
            OPC_LOAD:   legal = funct3 inside {F3_B, F3_H, F3_W, F3_BU, F3_HU};
            OPC_STORE:  legal = funct3 inside {F3_B, F3_H, F3_W};  // Upper imm bits ignored
            OPC_BRANCH: legal = funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
            OPC_JAL:    legal = 1'b1;
            OPC_JALR:   legal = (funct3 == 3'b000);
            OPC_AUIPC:  legal = 1'b1;
            OPC_SYSTEM: legal = 1'b0;  // Ebreak flagged on its own below
            default:    legal = 1'b0;  // Lui, fence and the rest
        endcase
    end

    always_comb begin
        alu_op        = ALU_ADD;  // Inactive set is all zero
        op1_sel       = OP1_RS1;
        op2_sel       = OP2_NONE;
        static_pc_sel = PC_SEQ;
        rf_we         = 1'b0;
        mem_en        = 1'b0;
        mem_wen       = 1'b0;
        wb_sel        = WB_NONE;
        mem_access    = MEM_ACCESS_NONE;
        is_branch     = 1'b0;
        if (legal) begin
            case (opcode)
                OPC_OP: begin
                    alu_op  = alu_fn;
                    op2_sel = OP2_RS2;
                    rf_we   = 1'b1;
                    wb_sel  = WB_ALU;
                end
                OPC_OP_IMM: begin
                    alu_op  = alu_fn;
                    op2_sel = OP2_IMM_I;
                    rf_we   = 1'b1;
                    wb_sel  = WB_ALU;
                end
                OPC_LOAD: begin
                    op2_sel    = OP2_IMM_I;  // Address = rs1 + imm
                    rf_we      = 1'b1;
                    mem_en     = 1'b1;
                    wb_sel     = WB_MEM;
                    mem_access = funct3;
                end
                OPC_STORE: begin
                    op2_sel    = OP2_IMM_S;
                    mem_en     = 1'b1;
                    mem_wen    = 1'b1;
                    mem_access = funct3;
                end
                OPC_BRANCH: begin
                    is_branch = 1'b1;    // Target chosen in branch_resolve
                    wb_sel    = WB_ALU;  // No rf_we, so harmless
                end
                OPC_JAL: begin
                    static_pc_sel = PC_JAL;
                    rf_we         = 1'b1;
                    wb_sel        = WB_LINK;
                end
                OPC_JALR: begin
                    static_pc_sel = PC_JALR;
                    op2_sel       = OP2_IMM_I;
                    rf_we         = 1'b1;
                    wb_sel        = WB_LINK;
                end
                OPC_AUIPC: begin
                    op1_sel = OP1_PC;  // Pc + upper imm
                    rf_we   = 1'b1;
                    wb_sel  = WB_ALU;
                end
                default: begin
                end
            endcase
        end
    end

    assign is_ebreak = (inst == EBREAK_WORD);  // Whole word must match

endmodule

// ==== logic/branch_resolve.sv ====
// Next-PC select: resolves conditional branches from the compare flags
`timescale 1ns/1ps

module branch_resolve (
    input  logic                    is_branch,
    input  rv_isa_pkg::funct3_t     funct3,
    input  logic                    br_eq,          // Rs1 == rs2
    input  logic                    br_lt,          // Rs1 < rs2 signed
    input  logic                    br_ltu,         // Rs1 < rs2 unsigned
    input  core_ctrl_pkg::pc_sel_t  static_pc_sel,  // From the table for non-branches
    output core_ctrl_pkg::pc_sel_t  next_pc_sel
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic taken;

    // Condition by funct3, illegal codes already filtered by the table
    always_comb begin
        case (funct3)
            F3_BEQ:  taken = br_eq;
            F3_BNE:  taken = !br_eq;
            F3_BLT:  taken = br_lt;
            F3_BGE:  taken = !br_lt;
            F3_BLTU: taken = br_ltu;
            F3_BGEU: taken = !br_ltu;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (!is_branch) begin
            next_pc_sel = static_pc_sel;  // Jumps and sequential flow
        end else if (taken) begin
            next_pc_sel = PC_BRANCH;
        end else begin
            next_pc_sel = PC_SEQ;  // Fall through
        end
    end

endmodule

// ==== logic/decode_out_reg.sv ====
// Decode output stage: registers the control fields with a valid bit at the ID/EX boundary
`timescale 1ns/1ps

module decode_out_reg (
    input  logic                        clock,
    input  logic                        rst,
    input  logic                        inst_valid,
    input  core_ctrl_pkg::alu_op_t      dec_alu_op,
    input  core_ctrl_pkg::op1_sel_t     dec_op1_sel,
    input  core_ctrl_pkg::op2_sel_t     dec_op2_sel,
    input  core_ctrl_pkg::pc_sel_t      next_pc_sel,
    input  logic                        dec_rf_we,
    input  logic                        dec_mem_en,
    input  logic                        dec_mem_wen,
    input  core_ctrl_pkg::wb_sel_t      dec_wb_sel,
    input  core_ctrl_pkg::mem_access_t  dec_mem_access,
    input  logic                        dec_is_ebreak,
    output logic                        ctl_valid,
    output core_ctrl_pkg::alu_op_t      alu_op,
    output core_ctrl_pkg::op1_sel_t     op1_sel,
    output core_ctrl_pkg::op2_sel_t     op2_sel,
    output core_ctrl_pkg::pc_sel_t      pc_sel,
    output logic                        rf_we,
    output logic                        mem_en,
    output logic                        mem_wen,
    output core_ctrl_pkg::wb_sel_t      wb_sel,
    output core_ctrl_pkg::mem_access_t  mem_access,
    output logic                        is_ebreak
);
    import core_ctrl_pkg::*;

    always_ff @(posedge clock) begin
        if (rst || !inst_valid) begin
            ctl_valid  <= 1'b0;  // Bubble
            alu_op     <= ALU_ADD;
            op1_sel    <= OP1_RS1;
            op2_sel    <= OP2_NONE;
            pc_sel     <= PC_SEQ;
            rf_we      <= 1'b0;
            mem_en     <= 1'b0;
            mem_wen    <= 1'b0;
            wb_sel     <= WB_NONE;
            mem_access <= MEM_ACCESS_NONE;
            is_ebreak  <= 1'b0;
        end else begin
            ctl_valid  <= 1'b1;
            alu_op     <= dec_alu_op;
            op1_sel    <= dec_op1_sel;
            op2_sel    <= dec_op2_sel;
            pc_sel     <= next_pc_sel;
            rf_we      <= dec_rf_we;
            mem_en     <= dec_mem_en;
            mem_wen    <= dec_mem_wen;
            wb_sel     <= dec_wb_sel;
            mem_access <= dec_mem_access;
            is_ebreak  <= dec_is_ebreak;
        end
    end

    // Table side, sampled here since the table has no clock
    a_store_has_mem_en: assert property (@(posedge clock) disable iff (rst)
        inst_valid && dec_mem_wen |-> dec_mem_en);

    // A valid ebreak shows up next cycle without a register write
    a_ebreak_no_write: assert property (@(posedge clock) disable iff (rst)
        inst_valid && dec_is_ebreak |=> ctl_valid && is_ebreak && !rf_we);

    a_pc_sel_range: assert property (@(posedge clock) disable iff (rst)
        pc_sel <= PC_JAL);

endmodule

// ==== logic/decode_unit.sv ====
// Decode unit top: instruction table, branch resolver and registered output stage
`timescale 1ns/1ps

module decode_unit (
    input  logic                        clock,
    input  logic                        rst,
    input  logic                        inst_valid,  // Level, one word per cycle
    input  rv_isa_pkg::inst_t           inst,
    input  logic                        br_eq,       // Sampled with inst
    input  logic                        br_lt,
    input  logic                        br_ltu,
    output logic                        ctl_valid,
    output core_ctrl_pkg::alu_op_t      alu_op,
    output core_ctrl_pkg::op1_sel_t     op1_sel,
    output core_ctrl_pkg::op2_sel_t     op2_sel,
    output core_ctrl_pkg::pc_sel_t      pc_sel,
    output logic                        rf_we,
    output logic                        mem_en,
    output logic                        mem_wen,
    output core_ctrl_pkg::wb_sel_t      wb_sel,
    output core_ctrl_pkg::mem_access_t  mem_access,
    output logic                        is_ebreak
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    // Combinational decode, zero cycles
    alu_op_t     dec_alu_op;
    op1_sel_t    dec_op1_sel;
    op2_sel_t    dec_op2_sel;
    pc_sel_t     static_pc_sel;
    pc_sel_t     next_pc_sel;
    logic        dec_rf_we;
    logic        dec_mem_en;
    logic        dec_mem_wen;
    wb_sel_t     dec_wb_sel;
    mem_access_t dec_mem_access;
    logic        is_branch;
    logic        dec_is_ebreak;

    inst_ctrl_table u_table (
        .inst          (inst),
        .alu_op        (dec_alu_op),
        .op1_sel       (dec_op1_sel),
        .op2_sel       (dec_op2_sel),
        .static_pc_sel (static_pc_sel),
        .rf_we         (dec_rf_we),
        .mem_en        (dec_mem_en),
        .mem_wen       (dec_mem_wen),
        .wb_sel        (dec_wb_sel),
        .mem_access    (dec_mem_access),
        .is_branch     (is_branch),
        .is_ebreak     (dec_is_ebreak)
    );

    branch_resolve u_branch (
        .is_branch     (is_branch),
        .funct3        (inst[FUNCT3_MSB:FUNCT3_LSB]),
        .br_eq         (br_eq),
        .br_lt         (br_lt),
        .br_ltu        (br_ltu),
        .static_pc_sel (static_pc_sel),
        .next_pc_sel   (next_pc_sel)
    );

    // One-cycle ID/EX register
    decode_out_reg u_out (
        .clock          (clock),
        .rst            (rst),
        .inst_valid     (inst_valid),
        .dec_alu_op     (dec_alu_op),
        .dec_op1_sel    (dec_op1_sel),
        .dec_op2_sel    (dec_op2_sel),
        .next_pc_sel    (next_pc_sel),
        .dec_rf_we      (dec_rf_we),
        .dec_mem_en     (dec_mem_en),
        .dec_mem_wen    (dec_mem_wen),
        .dec_wb_sel     (dec_wb_sel),
        .dec_mem_access (dec_mem_access),
        .dec_is_ebreak  (dec_is_ebreak),
        .ctl_valid      (ctl_valid),
        .alu_op         (alu_op),
        .op1_sel        (op1_sel),
        .op2_sel        (op2_sel),
        .pc_sel         (pc_sel),
        .rf_we          (rf_we),
        .mem_en         (mem_en),
        .mem_wen        (mem_wen),
        .wb_sel         (wb_sel),
        .mem_access     (mem_access),
        .is_ebreak      (is_ebreak)
    );

endmodule

// ==== tb/tb_clock_gen.sv ====
// Testbench clock and reset source: 40 ns clock, synchronous reset held for three edges
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic rst
);
    localparam int HALF_PERIOD  = 20;  // ns
    localparam int RESET_CYCLES = 3;
    localparam int DRIVE_DELAY  = 2;   // Same skew as the stimulus

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY rst = 1'b0;  // Released just after the third edge
    end

endmodule

// ==== tb/tb_decode_unit.sv ====
// Decode unit testbench that checks directed and random words against a reference decode
`timescale 1ns/1ps

module tb_decode_unit;
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    typedef struct packed {
        logic        valid;
        alu_op_t     alu_op;
        op1_sel_t    op1_sel;
        op2_sel_t    op2_sel;
        pc_sel_t     pc_sel;
        logic        rf_we;
        logic        mem_en;
        logic        mem_wen;
        wb_sel_t     wb_sel;
        mem_access_t mem_access;
        logic        is_ebreak;
    } exp_t;

    localparam int CYCLE_LIMIT = 1000;  // About twice the ~520 cycles of tests
    localparam int DRIVE_DELAY = 2;     // ns after the rising edge

    logic        clock;
    logic        rst;
    logic        inst_valid;
    inst_t       inst;
    logic        br_eq;
    logic        br_lt;
    logic        br_ltu;
    logic        ctl_valid;
    alu_op_t     alu_op;
    op1_sel_t    op1_sel;
    op2_sel_t    op2_sel;
    pc_sel_t     pc_sel;
    logic        rf_we;
    logic        mem_en;
    logic        mem_wen;
    wb_sel_t     wb_sel;
    mem_access_t mem_access;
    logic        is_ebreak;

    exp_t expect_q[$];      // One entry per driven cycle
    int   seed        = 7;
    int   pushed      = 0;
    int   checked     = 0;
    int   cycle_count = 0;

    tb_clock_gen u_clk (
        .clock (clock),
        .rst   (rst)
    );

    decode_unit dut (
        .clock      (clock),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .br_eq      (br_eq),
        .br_lt      (br_lt),
        .br_ltu     (br_ltu),
        .ctl_valid  (ctl_valid),
        .alu_op     (alu_op),
        .op1_sel    (op1_sel),
        .op2_sel    (op2_sel),
        .pc_sel     (pc_sel),
        .rf_we      (rf_we),
        .mem_en     (mem_en),
        .mem_wen    (mem_wen),
        .wb_sel     (wb_sel),
        .mem_access (mem_access),
        .is_ebreak  (is_ebreak)
    );

    // Expected controls straight from the decode rules with flags as {ltu, lt, eq}
    function automatic exp_t ref_decode(input inst_t w, input logic valid,
                                        input logic [2:0] flags);
        exp_t    e;
        opcode_t opc;
        funct3_t f3;
        funct7_t f7;
        logic    shift;
        logic    alt;
        logic    cond;
        alu_op_t base_ops [8];
        e        = '0;
        opc      = w[6:0];
        f3       = w[14:12];
        f7       = w[31:25];
        shift    = (f3 == 3'b001) || (f3 == 3'b101);
        alt      = (f7 == 7'b0100000);
        base_ops = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
        if (!valid) return e;  // Bubble
        e.valid = 1'b1;
        if (w == EBREAK_WORD) begin
            e.is_ebreak = 1'b1;
            return e;
        end
        case (opc)
            OPC_OP: begin
                if (f7 == F7_BASE || (alt && (f3 == 3'b000 || f3 == 3'b101))) begin
                    e.alu_op  = alt ? base_ops[f3] + 5'd1 : base_ops[f3];  // Sub and sra sit one up
                    e.op2_sel = OP2_RS2;
                    e.rf_we   = 1'b1;
                    e.wb_sel  = WB_ALU;
                end
            end
            OPC_OP_IMM: begin
                if (!shift || f7 == F7_BASE || (alt && f3 == 3'b101)) begin
                    e.alu_op  = (alt && shift) ? base_ops[f3] + 5'd1 : base_ops[f3];
                    e.op2_sel = OP2_IMM_I;
                    e.rf_we   = 1'b1;
                    e.wb_sel  = WB_ALU;
                end
            end
            OPC_LOAD: begin
                if (f3 != 3'b011 && f3 <= 3'b101) begin
                    e.op2_sel    = OP2_IMM_I;
                    e.rf_we      = 1'b1;
                    e.mem_en     = 1'b1;
                    e.wb_sel     = WB_MEM;
                    e.mem_access = f3;
                end
            end
            OPC_STORE: begin
                if (f3 <= 3'b010) begin
                    e.op2_sel    = OP2_IMM_S;
                    e.mem_en     = 1'b1;
                    e.mem_wen    = 1'b1;
                    e.mem_access = f3;
                end
            end
            OPC_BRANCH: begin
                if (f3[2:1] != 2'b01) begin
                    cond     = (f3[2] ? (f3[1] ? flags[2] : flags[1]) : flags[0]) ^ f3[0];
                    e.pc_sel = cond ? PC_BRANCH : PC_SEQ;  // Odd funct3 inverts
                    e.wb_sel = WB_ALU;
                end
            end
            OPC_JAL: begin
                e.pc_sel = PC_JAL;
                e.rf_we  = 1'b1;
                e.wb_sel = WB_LINK;
            end
            OPC_JALR: begin
                if (f3 == 3'b000) begin
                    e.pc_sel  = PC_JALR;
                    e.op2_sel = OP2_IMM_I;
                    e.rf_we   = 1'b1;
                    e.wb_sel  = WB_LINK;
                end
            end
            OPC_AUIPC: begin
                e.op1_sel = OP1_PC;
                e.rf_we   = 1'b1;
                e.wb_sel  = WB_ALU;
            end
            default: begin
            end
        endcase
        return e;
    endfunction

    // Word with random rd, rs1, rs2
    function automatic inst_t make_word(input funct7_t f7, input funct3_t f3, input opcode_t opc);
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [4:0] rd;
        rs2 = 5'($random(seed));
        rs1 = 5'($random(seed));
        rd  = 5'($random(seed));
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_alu_op(input alu_op_t got, input alu_op_t exp);
        if (got !== exp) begin
            $display("MISMATCH alu_op got %h expected %h at %0t", got, exp, $time);
            abort_run();
        end
    endtask

    task automatic check_op1_sel(input op1_sel_t got, input op1_sel_t exp);
        if (got !== exp) begin
            $display("MISMATCH op1_sel got %h expected %h at %0t", got, exp, $time);
            abort_run();
        end
    endtask

    task automatic check_op2_sel(input op2_sel_t got, input op2_sel_t exp);
        if (got !== exp) begin
            $display("MISMATCH op2_sel got %h expected %h at %0t", got, exp, $time);
            abort_run();
        end
    endtask

    task automatic check_pc_sel(input pc_sel_t got, input pc_sel_t exp);
        if (got !== exp) begin
            $display("MISMATCH pc_sel got %h expected %h at %0t", got, exp, $time);
            abort_run();
        end
    endtask

    task automatic check_wb_sel(input wb_sel_t got, input wb_sel_t exp);
        if (got !== exp) begin
            $display("MISMATCH wb_sel got %h expected %h at %0t", got, exp, $time);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
            abort_run();
        end
    endtask

    task automatic check_mem_access(input mem_access_t got, input mem_access_t exp);
        if (got !== exp) begin
            $display("MISMATCH mem_access got %h expected %h at %0t", got, exp, $time);
            abort_run();
        end
    endtask

    // Set inputs now and queue what the DUT must show after the next edge
    task automatic apply(input logic valid, input inst_t w, input logic [2:0] flags);
        inst_valid = valid;
        inst       = w;
        br_eq      = flags[0];
        br_lt      = flags[1];
        br_ltu     = flags[2];
        expect_q.push_back(ref_decode(w, valid, flags));
        pushed++;
    endtask

    task automatic drive(input logic valid, input inst_t w, input logic [2:0] flags);
        @(posedge clock);
        #DRIVE_DELAY;
        apply(valid, w, flags);
    endtask

    // Pop at the capture edge and compare at the falling edge
    initial begin : compare_proc
        exp_t exp;
        forever begin
            @(posedge clock);
            if (expect_q.size() > 0) begin
                exp = expect_q.pop_front();
                if (rst) exp = '0;  // Reset overrides the word
                @(negedge clock);
                check_flag("ctl_valid", ctl_valid, exp.valid);
                check_alu_op(alu_op, exp.alu_op);
                check_op1_sel(op1_sel, exp.op1_sel);
                check_op2_sel(op2_sel, exp.op2_sel);
                check_pc_sel(pc_sel, exp.pc_sel);
                check_flag("rf_we", rf_we, exp.rf_we);
                check_flag("mem_en", mem_en, exp.mem_en);
                check_flag("mem_wen", mem_wen, exp.mem_wen);
                check_wb_sel(wb_sel, exp.wb_sel);
                check_mem_access(mem_access, exp.mem_access);
                check_flag("is_ebreak", is_ebreak, exp.is_ebreak);
                checked++;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
            abort_run();
        end
    end

    initial begin : stimulus
        logic [31:0] r;
        logic [2:0]  fl;
        funct7_t     f7;
        inst_t       w;
        opcode_t     opc_list [9];
        opc_list = '{OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_STORE, OPC_BRANCH,
                     OPC_JAL, OPC_JALR, OPC_AUIPC, OPC_SYSTEM};
        apply(1'b0, '0, 3'b000);  // Known inputs from time zero

        // Valid add words held off by reset
        repeat (4) drive(1'b1, make_word(F7_BASE, 3'b000, OPC_OP), 3'b000);

        for (int f = 0; f < 8; f++) begin
            fl = 3'($random(seed));
            drive(1'b1, make_word(F7_BASE, funct3_t'(f), OPC_OP), fl);
        end
        drive(1'b1, make_word(F7_ALT, 3'b000, OPC_OP), 3'b000);      // Sub
        drive(1'b1, make_word(F7_ALT, F3_SRL_SRA, OPC_OP), 3'b000);  // Sra
        for (int f = 0; f < 8; f++) begin
            f7 = funct7_t'($random(seed));
            if (f == 1 || f == 5) f7 = F7_BASE;  // Slli and srli
            drive(1'b1, make_word(f7, funct3_t'(f), OPC_OP_IMM), 3'b000);
        end
        drive(1'b1, make_word(F7_ALT, F3_SRL_SRA, OPC_OP_IMM), 3'b000);  // Srai
        for (int f = 0; f < 8; f++) begin
            f7 = funct7_t'($random(seed));
            drive(1'b1, make_word(f7, funct3_t'(f), OPC_LOAD), 3'b000);
            drive(1'b1, make_word(f7 | 7'h01, funct3_t'(f), OPC_STORE), 3'b000);  // Upper imm set
        end
        w = $random(seed);
        drive(1'b1, {w[31:7], OPC_JAL}, 3'b111);
        drive(1'b1, make_word(funct7_t'($random(seed)), 3'b000, OPC_JALR), 3'b000);
        w = $random(seed);
        drive(1'b1, {w[31:7], OPC_AUIPC}, 3'b000);

        // Every branch funct3 under all flag combinations
        for (int f = 0; f < 8; f++) begin
            for (int k = 0; k < 8; k++) begin
                drive(1'b1, make_word(funct7_t'($random(seed)), funct3_t'(f), OPC_BRANCH),
                      k[2:0]);
            end
        end

        drive(1'b1, EBREAK_WORD, 3'b000);
        drive(1'b1, 32'h0000_0073, 3'b000);                                    // Ecall
        drive(1'b1, make_word(funct7_t'($random(seed)), 3'b010, 7'b0110111), 3'b000);  // Lui
        drive(1'b1, make_word(F7_BASE, 3'b010, OPC_JALR), 3'b000);
        drive(1'b1, make_word(7'h01, 3'b000, OPC_OP), 3'b000);       // Mul is not in rv32i
        drive(1'b1, make_word(F7_ALT, 3'b100, OPC_OP), 3'b000);

        repeat (3) drive(1'b0, make_word(F7_BASE, 3'b000, OPC_OP), 3'b000);  // Idle

        // Mostly known opcodes so legal decodes stay common
        for (int i = 0; i < 400; i++) begin
            r = $random(seed);
            w = $random(seed);
            if (r[2:0] != 3'd0) w[6:0] = opc_list[r[6:3] % 9];
            if (r[15:11] == 5'd0) w = EBREAK_WORD;
            drive(r[9:7] != 3'd0, w, r[12:10]);
        end
        drive(1'b0, '0, 3'b000);

        wait (checked == pushed);
        $display("Test passed");
        $finish;
    end

endmodule

// ==== vlog.f ====
logic/rv_isa_pkg.sv
logic/core_ctrl_pkg.sv
logic/inst_ctrl_table.sv
logic/branch_resolve.sv
logic/decode_out_reg.sv
logic/decode_unit.sv
tb/tb_clock_gen.sv
tb/tb_decode_unit.sv

// ==== Bender.yml ====
package:
  name: decode_unit

sources:
  - logic/rv_isa_pkg.sv
  - logic/core_ctrl_pkg.sv
  - logic/inst_ctrl_table.sv
  - logic/branch_resolve.sv
  - logic/decode_out_reg.sv
  - logic/decode_unit.sv
  - target: simulation
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_decode_unit.sv
